//--- sources.f
design/i3c_bus_pkg.sv
design/ccc_pkg.sv
design/ccc_data_if.sv
design/ccc_sequencer.sv
design/ccc_set_regs.sv
design/ccc_get_source.sv
design/ccc_top.sv
bench/tb_clock_gen.sv
bench/tb_ccc_top.sv

//--- Makefile
TOP := tb_ccc_top
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build output and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f sources.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/tb_ccc_top.sv
// Testbench for the CCC handler with a bus model, LFSR stimulus and assertion checks
`timescale 1ns/1ps

module tb_ccc_top;

  // About 650 cycles are needed with the longest bus delays
  localparam int CycleLimit = 4000;

  localparam i3c_bus_pkg::addr_t DynAddr = 7'h2A;
  localparam i3c_bus_pkg::addr_t StaAddr = 7'h51;
  localparam i3c_bus_pkg::addr_t ForeignAddr = 7'h33;

  logic clk_i;
  logic rst_ni;
  ccc_pkg::ccc_code_t ccc_i;
  logic ccc_valid_i;
  logic done_fsm_o;
  logic bus_rstart_det_i;
  logic bus_stop_det_i;
  logic bus_rx_done_i;
  i3c_bus_pkg::data_t bus_rx_data_i;
  logic bus_rx_req_bit_o;
  logic bus_rx_req_byte_o;
  logic bus_tx_done_i;
  logic bus_tx_req_bit_o;
  logic bus_tx_req_byte_o;
  i3c_bus_pkg::data_t bus_tx_req_value_o;
  logic bus_tx_sel_od_pp_o;
  i3c_bus_pkg::addr_t target_sta_address_i;
  logic target_sta_address_valid_i;
  i3c_bus_pkg::addr_t target_dyn_address_i;
  logic target_dyn_address_valid_i;
  i3c_bus_pkg::data_t get_bcr_i;
  i3c_bus_pkg::data_t get_dcr_i;
  i3c_bus_pkg::len_t get_mwl_i;
  i3c_bus_pkg::len_t get_mrl_i;
  i3c_bus_pkg::pid_t get_pid_i;
  logic set_mwl_o;
  i3c_bus_pkg::len_t mwl_o;
  logic set_mrl_o;
  i3c_bus_pkg::len_t mrl_o;
  logic enec_ibi_o;
  logic enec_crr_o;
  logic enec_hj_o;
  logic disec_ibi_o;
  logic disec_crr_o;
  logic disec_hj_o;

  // Bus model capture and expected values
  logic cap_stb;
  i3c_bus_pkg::data_t cap_value;
  logic cap_sel;
  i3c_bus_pkg::data_t exp_value;
  logic exp_sel;
  logic expect_quiet;
  logic check_stb;
  logic stop_q;
  i3c_bus_pkg::len_t exp_mwl;
  i3c_bus_pkg::len_t exp_mrl;
  logic [2:0] exp_enec;
  logic [2:0] exp_disec;
  int exp_mwl_pulses;
  int exp_mrl_pulses;
  int mwl_pulses;
  int mrl_pulses;
  int cycle_count = 0;
  logic [31:0] lfsr_state = 32'h8860f7fc;
  i3c_bus_pkg::data_t wr_bytes [3];
  i3c_bus_pkg::data_t get_bytes [$];

  logic [5:0] activity;
  logic [2:0] enec_bits;
  logic [2:0] disec_bits;

  assign activity = {bus_rx_req_bit_o, bus_rx_req_byte_o, bus_tx_req_bit_o,
                     bus_tx_req_byte_o, set_mwl_o, set_mrl_o};
  assign enec_bits = {enec_hj_o, enec_crr_o, enec_ibi_o};
  assign disec_bits = {disec_hj_o, disec_crr_o, disec_ibi_o};

  tb_clock_gen i_clock_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  // Signal names above match the DUT ports
  ccc_top i_ccc_top (.*);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stop_q <= 1'b0;
      mwl_pulses <= 0;
      mrl_pulses <= 0;
    end else begin
      stop_q <= bus_stop_det_i;
      if (set_mwl_o) mwl_pulses <= mwl_pulses + 1;
      if (set_mrl_o) mrl_pulses <= mrl_pulses + 1;
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == CycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("Regression failed");
      $fatal(1, "Simulation timed out");
    end
  end

  // Exactly one done pulse, in the cycle after a stop
  a_done_after_stop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_fsm_o == stop_q)
    else report_mismatch("done_fsm_o", 64'($sampled(done_fsm_o)), 64'($sampled(stop_q)));

  a_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    expect_quiet |-> activity == '0)
    else report_mismatch("requests and set strobes", 64'($sampled(activity)), 64'd0);

  a_tx_value: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cap_stb |-> cap_value == exp_value)
    else report_mismatch("bus_tx_req_value_o", 64'($sampled(cap_value)),
                         64'($sampled(exp_value)));

  a_tx_sel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cap_stb |-> cap_sel == exp_sel)
    else report_mismatch("bus_tx_sel_od_pp_o", 64'($sampled(cap_sel)), 64'($sampled(exp_sel)));

  a_mwl_on_set: assert property (@(posedge clk_i) disable iff (!rst_ni)
    set_mwl_o |-> mwl_o == exp_mwl)
    else report_mismatch("mwl_o", 64'($sampled(mwl_o)), 64'($sampled(exp_mwl)));

  a_mrl_on_set: assert property (@(posedge clk_i) disable iff (!rst_ni)
    set_mrl_o |-> mrl_o == exp_mrl)
    else report_mismatch("mrl_o", 64'($sampled(mrl_o)), 64'($sampled(exp_mrl)));

  a_mwl_pulses: assert property (@(posedge clk_i) disable iff (!rst_ni)
    check_stb |-> mwl_pulses == exp_mwl_pulses)
    else report_mismatch("set_mwl_o pulses", 64'($sampled(mwl_pulses)),
                         64'($sampled(exp_mwl_pulses)));

  a_mrl_pulses: assert property (@(posedge clk_i) disable iff (!rst_ni)
    check_stb |-> mrl_pulses == exp_mrl_pulses)
    else report_mismatch("set_mrl_o pulses", 64'($sampled(mrl_pulses)),
                         64'($sampled(exp_mrl_pulses)));

  // Lengths and event levels hold between writes
  a_mwl_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    check_stb |-> mwl_o == exp_mwl)
    else report_mismatch("mwl_o", 64'($sampled(mwl_o)), 64'($sampled(exp_mwl)));

  a_mrl_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    check_stb |-> mrl_o == exp_mrl)
    else report_mismatch("mrl_o", 64'($sampled(mrl_o)), 64'($sampled(exp_mrl)));

  a_enec: assert property (@(posedge clk_i) disable iff (!rst_ni)
    check_stb |-> enec_bits == exp_enec)
    else report_mismatch("enec hj/crr/ibi", 64'($sampled(enec_bits)), 64'($sampled(exp_enec)));

  a_disec: assert property (@(posedge clk_i) disable iff (!rst_ni)
    check_stb |-> disec_bits == exp_disec)
    else report_mismatch("disec hj/crr/ibi", 64'($sampled(disec_bits)),
                         64'($sampled(exp_disec)));

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
    $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, expected);
    $display("Regression failed");
    $fatal(1, "Check on %s failed", name);
  endtask

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] next_lfsr(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int width);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < width; i++) begin
      lfsr_state = next_lfsr(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic answer_rx(input i3c_bus_pkg::data_t value);
    int delay;
    delay = int'(rand_bits(2)) + 1;
    while (!(bus_rx_req_bit_o || bus_rx_req_byte_o)) next_cycle();
    repeat (delay - 1) next_cycle();
    bus_rx_data_i = value;
    bus_rx_done_i = 1'b1;
    next_cycle();
    bus_rx_done_i = 1'b0;
  endtask

  task automatic answer_tx(input i3c_bus_pkg::data_t value, input logic sel);
    int delay;
    delay = int'(rand_bits(2)) + 1;
    while (!(bus_tx_req_bit_o || bus_tx_req_byte_o)) next_cycle();
    repeat (delay - 1) next_cycle();
    cap_value = bus_tx_req_value_o;
    cap_sel = bus_tx_sel_od_pp_o;
    exp_value = value;
    exp_sel = sel;
    cap_stb = 1'b1;
    bus_tx_done_i = 1'b1;
    next_cycle();
    cap_stb = 1'b0;
    bus_tx_done_i = 1'b0;
  endtask

  // Held until the command T-bit is requested
  task automatic begin_command(input ccc_pkg::ccc_code_t code);
    ccc_i = code;
    ccc_valid_i = 1'b1;
    next_cycle();
    while (!bus_rx_req_bit_o) next_cycle();
    ccc_valid_i = 1'b0;
    answer_rx(8'h00);
  endtask

  task automatic hold_quiet(input int cycles);
    expect_quiet = 1'b1;
    repeat (cycles) next_cycle();
    expect_quiet = 1'b0;
  endtask

  task automatic check_outputs();
    check_stb = 1'b1;
    next_cycle();
    check_stb = 1'b0;
  endtask

  task automatic end_with_stop();
    bus_stop_det_i = 1'b1;
    next_cycle();
    bus_stop_det_i = 1'b0;
    repeat (3) next_cycle();
    check_outputs();
  endtask

  // ACK is 0 and NACK is 1, both open-drain
  task automatic address_target(input i3c_bus_pkg::addr_t addr, input logic rnw,
                                input logic ack_value);
    bus_rstart_det_i = 1'b1;
    next_cycle();
    bus_rstart_det_i = 1'b0;
    answer_rx({addr, rnw});
    answer_tx({7'h00, ack_value}, 1'b0);
  endtask

  task automatic fill_bytes();
    for (int i = 0; i < 3; i++) wr_bytes[i] = i3c_bus_pkg::data_t'(rand_bits(8));
  endtask

  task automatic send_bytes(input int count);
    for (int i = 0; i < count; i++) begin
      answer_rx(wr_bytes[i]);
      answer_rx({7'h00, ~^wr_bytes[i]});
    end
  endtask

  // Lengths take the first two bytes MSB first, events take bits 0, 1 and 3
  task automatic expect_write(input ccc_pkg::ccc_code_t code, input int count);
    case (code)
      ccc_pkg::BcastSetmwl, ccc_pkg::DirSetmwl: begin
        if (count >= 2) begin
          exp_mwl = {wr_bytes[0], wr_bytes[1]};
          exp_mwl_pulses++;
        end
      end
      ccc_pkg::BcastSetmrl, ccc_pkg::DirSetmrl: begin
        if (count >= 2) begin
          exp_mrl = {wr_bytes[0], wr_bytes[1]};
          exp_mrl_pulses++;
        end
      end
      ccc_pkg::BcastEnec, ccc_pkg::DirEnec: begin
        if (count >= 1) exp_enec = {wr_bytes[0][3], wr_bytes[0][1], wr_bytes[0][0]};
      end
      ccc_pkg::BcastDisec, ccc_pkg::DirDisec: begin
        if (count >= 1) exp_disec = {wr_bytes[0][3], wr_bytes[0][1], wr_bytes[0][0]};
      end
      default: begin
      end
    endcase
  endtask

  task automatic write_broadcast(input ccc_pkg::ccc_code_t code, input int count);
    fill_bytes();
    expect_write(code, count);
    begin_command(code);
    send_bytes(count);
    end_with_stop();
  endtask

  task automatic build_get_bytes(input ccc_pkg::ccc_code_t code);
    get_bytes.delete();
    case (code)
      ccc_pkg::DirGetbcr: get_bytes.push_back(get_bcr_i);
      ccc_pkg::DirGetdcr: get_bytes.push_back(get_dcr_i);
      ccc_pkg::DirGetmwl: begin
        get_bytes.push_back(get_mwl_i[15:8]);
        get_bytes.push_back(get_mwl_i[7:0]);
      end
      ccc_pkg::DirGetmrl: begin
        get_bytes.push_back(get_mrl_i[15:8]);
        get_bytes.push_back(get_mrl_i[7:0]);
        get_bytes.push_back(8'hFF);
      end
      ccc_pkg::DirGetpid: begin
        for (int i = 5; i >= 0; i--) get_bytes.push_back(get_pid_i[i * 8 +: 8]);
      end
      default: begin
      end
    endcase
  endtask

  // T-bit of 1 while more bytes follow
  task automatic read_from_target(input ccc_pkg::ccc_code_t code);
    build_get_bytes(code);
    begin_command(code);
    address_target(DynAddr, 1'b1, 1'b0);
    for (int i = 0; i < get_bytes.size(); i++) begin
      answer_tx(get_bytes[i], 1'b1);
      answer_tx({7'h00, i < get_bytes.size() - 1}, 1'b1);
    end
    hold_quiet(4);
    end_with_stop();
  endtask

  initial begin
    ccc_i = '0;
    ccc_valid_i = 1'b0;
    bus_rstart_det_i = 1'b0;
    bus_stop_det_i = 1'b0;
    bus_rx_done_i = 1'b0;
    bus_rx_data_i = '0;
    bus_tx_done_i = 1'b0;
    target_sta_address_i = StaAddr;
    target_sta_address_valid_i = 1'b1;
    target_dyn_address_i = DynAddr;
    target_dyn_address_valid_i = 1'b0;
    get_bcr_i = i3c_bus_pkg::data_t'(rand_bits(8));
    get_dcr_i = i3c_bus_pkg::data_t'(rand_bits(8));
    get_mwl_i = i3c_bus_pkg::len_t'(rand_bits(16));
    get_mrl_i = i3c_bus_pkg::len_t'(rand_bits(16));
    get_pid_i = {16'(rand_bits(16)), rand_bits(32)};
    cap_stb = 1'b0;
    cap_value = '0;
    cap_sel = 1'b0;
    exp_value = '0;
    exp_sel = 1'b0;
    expect_quiet = 1'b0;
    check_stb = 1'b0;
    exp_mwl = '0;
    exp_mrl = '0;
    exp_enec = '0;
    exp_disec = '0;
    exp_mwl_pulses = 0;
    exp_mrl_pulses = 0;

    wait (rst_ni);
    next_cycle();

    // Reset values, then a lone stop
    hold_quiet(3);
    check_outputs();
    end_with_stop();

    write_broadcast(ccc_pkg::BcastSetmwl, 2);
    write_broadcast(ccc_pkg::BcastSetmrl, 3);

    repeat (3) begin
      write_broadcast(ccc_pkg::BcastEnec, 1);
      write_broadcast(ccc_pkg::BcastDisec, 1);
    end

    // Dynamic address wins while both are valid
    target_dyn_address_valid_i = 1'b1;
    read_from_target(ccc_pkg::DirGetbcr);
    read_from_target(ccc_pkg::DirGetdcr);
    read_from_target(ccc_pkg::DirGetmwl);
    read_from_target(ccc_pkg::DirGetmrl);
    read_from_target(ccc_pkg::DirGetpid);
    read_from_target(ccc_pkg::DirEnec);

    // Static address is not ours while the dynamic one is valid
    begin_command(ccc_pkg::DirGetbcr);
    address_target(StaAddr, 1'b1, 1'b1);
    hold_quiet(4);
    end_with_stop();

    // Foreign address first, then the static one
    target_dyn_address_valid_i = 1'b0;
    fill_bytes();
    begin_command(ccc_pkg::DirSetmwl);
    address_target(ForeignAddr, 1'b0, 1'b1);
    hold_quiet(5);
    address_target(StaAddr, 1'b0, 1'b0);
    expect_write(ccc_pkg::DirSetmwl, 2);
    send_bytes(2);
    end_with_stop();

    // Broadcast address inside a direct frame
    begin_command(ccc_pkg::DirSetmrl);
    address_target(i3c_bus_pkg::RsvdAddr, 1'b0, 1'b0);
    hold_quiet(5);
    end_with_stop();

    $display("Regression passed");
    $finish;
  end

endmodule

//--- bench/tb_clock_gen.sv
// Testbench clock and reset generator with a 10 ns clock and a two cycle reset
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Released just after the second rising edge
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

//--- design/ccc_top.sv
// CCC handler top connecting the sequencer, SET registers and GET source
`timescale 1ns/1ps

module ccc_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  ccc_pkg::ccc_code_t ccc_i,
  input  logic               ccc_valid_i,
  output logic               done_fsm_o,
  input  logic               bus_rstart_det_i,
  input  logic               bus_stop_det_i,
  input  logic               bus_rx_done_i,
  input  i3c_bus_pkg::data_t bus_rx_data_i,
  output logic               bus_rx_req_bit_o,
  output logic               bus_rx_req_byte_o,
  input  logic               bus_tx_done_i,
  output logic               bus_tx_req_bit_o,
  output logic               bus_tx_req_byte_o,
  output i3c_bus_pkg::data_t bus_tx_req_value_o,
  output logic               bus_tx_sel_od_pp_o,
  input  i3c_bus_pkg::addr_t target_sta_address_i,
  input  logic               target_sta_address_valid_i,
  input  i3c_bus_pkg::addr_t target_dyn_address_i,
  input  logic               target_dyn_address_valid_i,
  input  i3c_bus_pkg::data_t get_bcr_i,
  input  i3c_bus_pkg::data_t get_dcr_i,
  input  i3c_bus_pkg::len_t  get_mwl_i,
  input  i3c_bus_pkg::len_t  get_mrl_i,
  input  i3c_bus_pkg::pid_t  get_pid_i,
  output logic               set_mwl_o,
  output i3c_bus_pkg::len_t  mwl_o,
  output logic               set_mrl_o,
  output i3c_bus_pkg::len_t  mrl_o,
  output logic               enec_ibi_o,
  output logic               enec_crr_o,
  output logic               enec_hj_o,
  output logic               disec_ibi_o,
  output logic               disec_crr_o,
  output logic               disec_hj_o
);

  ccc_data_if ccc_data ();

  ccc_sequencer i_ccc_sequencer (
    .clk_i                      (clk_i),
    .rst_ni                     (rst_ni),
    .ccc_i                      (ccc_i),
    .ccc_valid_i                (ccc_valid_i),
    .done_fsm_o                 (done_fsm_o),
    .bus_rstart_det_i           (bus_rstart_det_i),
    .bus_stop_det_i             (bus_stop_det_i),
    .bus_rx_done_i              (bus_rx_done_i),
    .bus_rx_data_i              (bus_rx_data_i),
    .bus_rx_req_bit_o           (bus_rx_req_bit_o),
    .bus_rx_req_byte_o          (bus_rx_req_byte_o),
    .bus_tx_done_i              (bus_tx_done_i),
    .bus_tx_req_bit_o           (bus_tx_req_bit_o),
    .bus_tx_req_byte_o          (bus_tx_req_byte_o),
    .bus_tx_req_value_o         (bus_tx_req_value_o),
    .bus_tx_sel_od_pp_o         (bus_tx_sel_od_pp_o),
    .target_sta_address_i       (target_sta_address_i),
    .target_sta_address_valid_i (target_sta_address_valid_i),
    .target_dyn_address_i       (target_dyn_address_i),
    .target_dyn_address_valid_i (target_dyn_address_valid_i),
    .data_o                     (ccc_data)
  );

  ccc_set_regs i_ccc_set_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .data_i      (ccc_data),
    .set_mwl_o   (set_mwl_o),
    .mwl_o       (mwl_o),
    .set_mrl_o   (set_mrl_o),
    .mrl_o       (mrl_o),
    .enec_ibi_o  (enec_ibi_o),
    .enec_crr_o  (enec_crr_o),
    .enec_hj_o   (enec_hj_o),
    .disec_ibi_o (disec_ibi_o),
    .disec_crr_o (disec_crr_o),
    .disec_hj_o  (disec_hj_o)
  );

  ccc_get_source i_ccc_get_source (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .get_bcr_i (get_bcr_i),
    .get_dcr_i (get_dcr_i),
    .get_mwl_i (get_mwl_i),
    .get_mrl_i (get_mrl_i),
    .get_pid_i (get_pid_i),
    .data_io   (ccc_data)
  );

endmodule

//--- design/ccc_get_source.sv
// CCC GET source counting and selecting the bytes returned for direct GET commands
`timescale 1ns/1ps

module ccc_get_source (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  i3c_bus_pkg::data_t get_bcr_i,
  input  i3c_bus_pkg::data_t get_dcr_i,
  input  i3c_bus_pkg::len_t  get_mwl_i,
  input  i3c_bus_pkg::len_t  get_mrl_i,
  input  i3c_bus_pkg::pid_t  get_pid_i,
  ccc_data_if.getter         data_io
);

  // Bytes left to send, the current one included
  ccc_pkg::cnt_t count_q;
  i3c_bus_pkg::data_t [5:0] pid_bytes;
  i3c_bus_pkg::data_t tx_byte;

  assign pid_bytes = get_pid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (data_io.tx_load) begin
      count_q <= ccc_pkg::get_len(data_io.code);
    end else if (data_io.tx_next && count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  // Highest count selects the MSB byte
  always_comb begin
    tx_byte = '0;
    if (count_q != '0) begin
      case (data_io.code)
        ccc_pkg::DirGetbcr: tx_byte = get_bcr_i;
        ccc_pkg::DirGetdcr: tx_byte = get_dcr_i;
        ccc_pkg::DirGetmwl: begin
          tx_byte = (count_q == ccc_pkg::cnt_t'(2)) ? get_mwl_i[15:8] : get_mwl_i[7:0];
        end
        ccc_pkg::DirGetmrl: begin
          if (count_q == ccc_pkg::cnt_t'(3)) tx_byte = get_mrl_i[15:8];
          else if (count_q == ccc_pkg::cnt_t'(2)) tx_byte = get_mrl_i[7:0];
          else tx_byte = ccc_pkg::MrlFillByte;
        end
        ccc_pkg::DirGetpid: tx_byte = pid_bytes[count_q - 1'b1];
        default: tx_byte = '0;
      endcase
    end
  end

  assign data_io.tx_data = tx_byte;
  assign data_io.tx_last = (count_q == ccc_pkg::cnt_t'(1));

  a_next_with_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_io.tx_next |-> count_q != '0);

endmodule

//--- design/ccc_set_regs.sv
// CCC SET registers building max lengths and event enables from received bytes
`timescale 1ns/1ps

module ccc_set_regs (
  input  logic              clk_i,
  input  logic              rst_ni,
  ccc_data_if.setter        data_i,
  output logic              set_mwl_o,
  output i3c_bus_pkg::len_t mwl_o,
  output logic              set_mrl_o,
  output i3c_bus_pkg::len_t mrl_o,
  output logic              enec_ibi_o,
  output logic              enec_crr_o,
  output logic              enec_hj_o,
  output logic              disec_ibi_o,
  output logic              disec_crr_o,
  output logic              disec_hj_o
);

  logic first_byte;
  logic second_byte;

  assign first_byte = (data_i.rx_cnt == ccc_pkg::cnt_t'(0));
  assign second_byte = (data_i.rx_cnt == ccc_pkg::cnt_t'(1));

  // Lengths arrive MSB first, later bytes are ignored
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      set_mwl_o <= 1'b0;
      set_mrl_o <= 1'b0;
      mwl_o <= '0;
      mrl_o <= '0;
      enec_ibi_o <= 1'b0;
      enec_crr_o <= 1'b0;
      enec_hj_o <= 1'b0;
      disec_ibi_o <= 1'b0;
      disec_crr_o <= 1'b0;
      disec_hj_o <= 1'b0;
    end else begin
      set_mwl_o <= 1'b0;
      set_mrl_o <= 1'b0;
      if (data_i.rx_stb) begin
        case (data_i.code)
          ccc_pkg::BcastSetmwl, ccc_pkg::DirSetmwl: begin
            if (first_byte) mwl_o[15:8] <= data_i.rx_byte;
            if (second_byte) begin
              mwl_o[7:0] <= data_i.rx_byte;
              set_mwl_o <= 1'b1;
            end
          end
          ccc_pkg::BcastSetmrl, ccc_pkg::DirSetmrl: begin
            if (first_byte) mrl_o[15:8] <= data_i.rx_byte;
            if (second_byte) begin
              mrl_o[7:0] <= data_i.rx_byte;
              set_mrl_o <= 1'b1;
            end
          end
          ccc_pkg::BcastEnec, ccc_pkg::DirEnec: begin
            if (first_byte) begin
              enec_ibi_o <= data_i.rx_byte[ccc_pkg::EvtIbiBit];
              enec_crr_o <= data_i.rx_byte[ccc_pkg::EvtCrrBit];
              enec_hj_o <= data_i.rx_byte[ccc_pkg::EvtHjBit];
            end
          end
          ccc_pkg::BcastDisec, ccc_pkg::DirDisec: begin
            if (first_byte) begin
              disec_ibi_o <= data_i.rx_byte[ccc_pkg::EvtIbiBit];
              disec_crr_o <= data_i.rx_byte[ccc_pkg::EvtCrrBit];
              disec_hj_o <= data_i.rx_byte[ccc_pkg::EvtHjBit];
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  a_one_set_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(set_mwl_o && set_mrl_o));

endmodule

//--- design/ccc_sequencer.sv
// CCC sequencer FSM walking the frame, matching addresses and driving bus requests
`timescale 1ns/1ps

module ccc_sequencer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  ccc_pkg::ccc_code_t    ccc_i,
  input  logic                  ccc_valid_i,
  output logic                  done_fsm_o,
  input  logic                  bus_rstart_det_i,
  input  logic                  bus_stop_det_i,
  input  logic                  bus_rx_done_i,
  input  i3c_bus_pkg::data_t    bus_rx_data_i,
  output logic                  bus_rx_req_bit_o,
  output logic                  bus_rx_req_byte_o,
  input  logic                  bus_tx_done_i,
  output logic                  bus_tx_req_bit_o,
  output logic                  bus_tx_req_byte_o,
  output i3c_bus_pkg::data_t    bus_tx_req_value_o,
  output logic                  bus_tx_sel_od_pp_o,
  input  i3c_bus_pkg::addr_t    target_sta_address_i,
  input  logic                  target_sta_address_valid_i,
  input  i3c_bus_pkg::addr_t    target_dyn_address_i,
  input  logic                  target_dyn_address_valid_i,
  ccc_data_if.sequencer         data_o
);

  typedef enum logic [3:0] {
    Idle,
    WaitCCC,
    RxTbit,
    RxByte,
    RxByteTbit,
    RxDirectAddr,
    TxAddrAck,
    RxData,
    RxDataTbit,
    TxData,
    TxDataTbit,
    WaitForBusCond,
    WaitForStop,
    DoneCCC
  } state_e;

  state_e state_q, state_d;

  ccc_pkg::ccc_code_t code_q;
  i3c_bus_pkg::addr_t addr_q;
  logic rnw_q;
  logic addr_stb_q;
  i3c_bus_pkg::data_t rx_byte_q;
  ccc_pkg::cnt_t rx_cnt_q;
  logic rx_stb_q;

  logic is_direct;
  logic is_rsvd_addr;
  logic is_our_addr;
  logic ack_read;
  logic get_empty;
  logic rstart_clr;

  assign is_direct = code_q[7];
  assign is_rsvd_addr = (addr_q == i3c_bus_pkg::RsvdAddr);
  assign ack_read = is_our_addr && !is_rsvd_addr && rnw_q;
  assign get_empty = (ccc_pkg::get_len(code_q) == '0);
  assign rstart_clr = bus_rstart_det_i &&
                      (state_q inside {RxByte, RxData, TxData, WaitForBusCond});

  // Dynamic address wins over static
  always_comb begin
    if (target_dyn_address_valid_i) begin
      is_our_addr = (addr_q == target_dyn_address_i);
    end else if (target_sta_address_valid_i) begin
      is_our_addr = (addr_q == target_sta_address_i);
    end else begin
      is_our_addr = 1'b0;
    end
  end

  always_comb begin
    state_d = state_q;
    done_fsm_o = 1'b0;
    bus_rx_req_bit_o = 1'b0;
    bus_rx_req_byte_o = 1'b0;
    bus_tx_req_bit_o = 1'b0;
    bus_tx_req_byte_o = 1'b0;
    bus_tx_req_value_o = '0;
    bus_tx_sel_od_pp_o = 1'b0;
    case (state_q)
      Idle: state_d = WaitCCC;
      WaitCCC: begin
        if (ccc_valid_i) state_d = RxTbit;
      end
      RxTbit: begin
        bus_rx_req_bit_o = 1'b1;
        if (bus_rx_done_i) state_d = is_direct ? RxByte : RxData;
      end
      // Direct command bytes are skipped until a repeated start
      RxByte: begin
        bus_rx_req_byte_o = !bus_rstart_det_i;
        if (bus_rstart_det_i) state_d = RxDirectAddr;
        else if (bus_rx_done_i) state_d = RxByteTbit;
      end
      RxByteTbit: begin
        bus_rx_req_bit_o = 1'b1;
        if (bus_rx_done_i) state_d = RxByte;
      end
      RxDirectAddr: begin
        bus_rx_req_byte_o = 1'b1;
        if (bus_rx_done_i) state_d = TxAddrAck;
      end
      TxAddrAck: begin
        bus_tx_req_bit_o = 1'b1;
        bus_tx_req_value_o = {7'h00, (is_our_addr || is_rsvd_addr) ?
                              i3c_bus_pkg::AckBit : i3c_bus_pkg::NackBit};
        if (bus_tx_done_i) begin
          if (is_rsvd_addr) state_d = WaitForStop;
          else if (ack_read) state_d = get_empty ? WaitForBusCond : TxData;
          else if (is_our_addr) state_d = RxData;
          else state_d = WaitForBusCond;
        end
      end
      RxData: begin
        bus_rx_req_byte_o = !bus_rstart_det_i;
        if (bus_rstart_det_i) state_d = RxDirectAddr;
        else if (bus_rx_done_i) state_d = RxDataTbit;
      end
      RxDataTbit: begin
        bus_rx_req_bit_o = 1'b1;
        if (bus_rx_done_i) state_d = RxData;
      end
      TxData: begin
        bus_tx_req_byte_o = 1'b1;
        bus_tx_req_value_o = data_o.tx_data;
        bus_tx_sel_od_pp_o = 1'b1;
        if (bus_rstart_det_i) state_d = RxDirectAddr;
        else if (bus_tx_done_i) state_d = TxDataTbit;
      end
      // T-bit of 1 means more data follows
      TxDataTbit: begin
        bus_tx_req_bit_o = 1'b1;
        bus_tx_req_value_o = {7'h00, !data_o.tx_last};
        bus_tx_sel_od_pp_o = 1'b1;
        if (bus_tx_done_i) state_d = data_o.tx_last ? WaitForBusCond : TxData;
      end
      WaitForBusCond: begin
        if (bus_rstart_det_i) state_d = RxDirectAddr;
      end
      // Only a stop leaves this state
      WaitForStop: state_d = WaitForStop;
      DoneCCC: begin
        done_fsm_o = 1'b1;
        state_d = Idle;
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      code_q <= '0;
      addr_q <= '0;
      rnw_q <= 1'b0;
      addr_stb_q <= 1'b0;
    end else begin
      state_q <= bus_stop_det_i ? DoneCCC : state_d;
      if (state_q == WaitCCC && ccc_valid_i) code_q <= ccc_i;
      addr_stb_q <= (state_q == RxDirectAddr) && bus_rx_done_i;
      if (state_q == RxDirectAddr && bus_rx_done_i) begin
        addr_q <= bus_rx_data_i[7:1];
        rnw_q <= bus_rx_data_i[0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == RxData && bus_rx_done_i) rx_byte_q <= bus_rx_data_i;
  end

  // Strobe lands one cycle after the T-bit, index advances after the strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_stb_q <= 1'b0;
      rx_cnt_q <= '0;
    end else begin
      rx_stb_q <= (state_q == RxDataTbit) && bus_rx_done_i && !bus_stop_det_i;
      if ((state_q == WaitCCC && ccc_valid_i) || rstart_clr) begin
        rx_cnt_q <= '0;
      end else if (rx_stb_q && rx_cnt_q != '1) begin
        rx_cnt_q <= rx_cnt_q + 1'b1;
      end
    end
  end

  assign data_o.code = code_q;
  assign data_o.rx_byte = rx_byte_q;
  assign data_o.rx_cnt = rx_cnt_q;
  assign data_o.rx_stb = rx_stb_q;
  // Count is loaded in the first ACK cycle, before the first byte
  assign data_o.tx_load = addr_stb_q && (state_q == TxAddrAck) && ack_read;
  assign data_o.tx_next = (state_q == TxDataTbit) && bus_tx_done_i;

  a_one_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({bus_rx_req_bit_o, bus_rx_req_byte_o, bus_tx_req_bit_o, bus_tx_req_byte_o}));

  // Transmit value held until the bus side finishes
  a_tx_value_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bus_tx_req_bit_o || bus_tx_req_byte_o) && !bus_tx_done_i &&
    !bus_stop_det_i && !bus_rstart_det_i |=> $stable(bus_tx_req_value_o));

endmodule

//--- design/ccc_data_if.sv
// CCC data interface carrying command and byte events to the SET and GET blocks
`timescale 1ns/1ps

interface ccc_data_if;

  ccc_pkg::ccc_code_t code;
  i3c_bus_pkg::data_t rx_byte;
  // Byte index within the current segment
  ccc_pkg::cnt_t rx_cnt;
  logic rx_stb;

  // Read side
  logic tx_load;
  logic tx_next;
  i3c_bus_pkg::data_t tx_data;
  logic tx_last;

  modport sequencer (
    output code, rx_byte, rx_cnt, rx_stb, tx_load, tx_next,
    input  tx_data, tx_last
  );

  modport setter (
    input code, rx_byte, rx_cnt, rx_stb
  );

  modport getter (
    input  code, tx_load, tx_next,
    output tx_data, tx_last
  );

endinterface

//--- design/ccc_pkg.sv
// CCC package with the command codes, GET byte counts and event bit positions
package ccc_pkg;

  // Bit 7 set means a direct command
  typedef logic [7:0] ccc_code_t;
  typedef logic [2:0] cnt_t;

  localparam ccc_code_t BcastEnec = 8'h00;
  localparam ccc_code_t BcastDisec = 8'h01;
  localparam ccc_code_t BcastSetmwl = 8'h09;
  localparam ccc_code_t BcastSetmrl = 8'h0A;
  localparam ccc_code_t DirEnec = 8'h80;
  localparam ccc_code_t DirDisec = 8'h81;
  localparam ccc_code_t DirSetmwl = 8'h89;
  localparam ccc_code_t DirSetmrl = 8'h8A;
  localparam ccc_code_t DirGetmwl = 8'h8B;
  localparam ccc_code_t DirGetmrl = 8'h8C;
  localparam ccc_code_t DirGetpid = 8'h8D;
  localparam ccc_code_t DirGetbcr = 8'h8E;
  localparam ccc_code_t DirGetdcr = 8'h8F;

  // Bits of the ENEC and DISEC byte
  localparam int EvtIbiBit = 0;
  localparam int EvtCrrBit = 1;
  localparam int EvtHjBit = 3;

  // Third GETMRL byte, max IBI payload
  localparam logic [7:0] MrlFillByte = 8'hFF;

  // Number of bytes returned by a direct GET, zero when not a GET
  function automatic cnt_t get_len(ccc_code_t code);
    case (code)
      DirGetbcr, DirGetdcr: return cnt_t'(1);
      DirGetmwl: return cnt_t'(2);
      DirGetmrl: return cnt_t'(3);
      DirGetpid: return cnt_t'(6);
      default: return '0;
    endcase
  endfunction

endpackage

//--- design/i3c_bus_pkg.sv
// I3C bus package with the address, byte and register value types and bus constants
package i3c_bus_pkg;

  // Target address without the RnW bit
  typedef logic [6:0] addr_t;

  // One byte on the bus
  typedef logic [7:0] data_t;

  // Maximum write or read length
  typedef logic [15:0] len_t;

  // Provisioned ID, sent MSB byte first
  typedef logic [47:0] pid_t;

  // Broadcast address, always ACKed
  localparam addr_t RsvdAddr = 7'h7E;

  // Open-drain ACK pulls SDA low
  localparam logic AckBit = 1'b0;
  localparam logic NackBit = 1'b1;

endpackage
